//--- Bender.yml
package:
  name: rename_unit

sources:
  - common/rename_pkg.sv
  - checkpoint/checkpoint_ram.sv
  - checkpoint/checkpoint_alloc.sv
  - rename/rename_map.sv
  - hdl/rename_unit.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/rename_unit_tb.sv

//--- checkpoint/checkpoint_alloc.sv
module checkpoint_alloc (
   input  logic                       clka,
   input  logic                       rst_n,
   input  logic                       alloc,      // A branch is renamed this cycle
   input  rename_pkg::resolve_t       resolve,    // Branch outcome from the branch unit
   output rename_pkg::checkpt_ndx_t   free_ndx,   // Slot the next branch will take
   output logic                       can_alloc   // That slot is not in use
);

   logic [rename_pkg::NCHECK-1:0] in_use;         // One bit per checkpoint slot
   rename_pkg::checkpt_ndx_t      tail;           // Next slot in ring order
   rename_pkg::checkpt_ndx_t      span;           // Distance from the resolving slot to tail
   logic [rename_pkg::NCHECK-1:0] kill_mask;      // Slots dropped by a mispredict

   // Slots are handed out strictly in ring order
   // When the tail slot is busy the ring is full
   assign free_ndx  = tail;
   assign can_alloc = ~in_use[tail];

   // ============================
   // Squash mask
   // ============================

   // A mispredict of slot k drops k and every younger slot up to tail minus one
   // A span of zero only happens when the ring is full and k is the oldest slot
   always_comb begin : squash
      rename_pkg::checkpt_ndx_t off;
      span = tail - resolve.ckpt;
      off  = '0;
      for (int i = 0; i < rename_pkg::NCHECK; i++) begin
         off          = rename_pkg::checkpt_ndx_t'(i) - resolve.ckpt;  // Age offset from k
         kill_mask[i] = (span == '0) || (off < span);
      end
   end

   // ============================
   // Slot state
   // ============================

   always_ff @(posedge clka or negedge rst_n) begin
      if (!rst_n) begin
         in_use <= '0;                            // No branches outstanding
         tail   <= '0;
      end else begin
         if (resolve.valid) begin
            if (resolve.mispredict) begin
               in_use <= in_use & ~kill_mask;     // Free the wrong path checkpoints
               tail   <= resolve.ckpt;            // Reuse from the squashed branch onward
            end else begin
               in_use[resolve.ckpt] <= 1'b0;      // Correct path, only its own slot goes
            end
         end
         // rdy is low on a mispredict so alloc never meets the squash
         if (alloc) begin
            in_use[tail] <= 1'b1;
            tail         <= tail + 1'b1;
         end
      end
   end

   // ============================
   // Checks
   // ============================

   // The top level must not accept a branch while the ring is full
   a_alloc_has_room : assert property (
      @(posedge clka) disable iff (!rst_n) alloc |-> can_alloc
   ) else $error("checkpoint allocated with no free slot");

   // The branch unit may only resolve branches that still hold a checkpoint
   a_resolve_in_use : assert property (
      @(posedge clka) disable iff (!rst_n) resolve.valid |-> in_use[resolve.ckpt]
   ) else $error("resolve names checkpoint %0d which is not in use", resolve.ckpt);

endmodule

//--- checkpoint/checkpoint_ram.sv
module checkpoint_ram (
   input  logic                       clka,
   input  logic                       wr_en,      // Save a snapshot at this edge
   input  rename_pkg::checkpt_ndx_t   wr_ndx,     // Slot being written, the allocator tail
   input  rename_pkg::checkpoint_t    wr_data,    // Map and avail before the branch renames
   input  rename_pkg::checkpt_ndx_t   rd_ndx,     // Slot named by the resolving branch
   output rename_pkg::checkpoint_t    rd_data     // Snapshot used for the restore
);

   // ============================
   // Storage
   // ============================

   // Small and wide with an asynchronous read, so this maps to LUT RAM
   // The records hold only payload and are not reset
   rename_pkg::checkpoint_t mem [0:rename_pkg::NCHECK-1];

   // Start every slot from the reset rename state
   // A restore from a slot never written then still yields a sane map
   initial begin
      for (int n = 0; n < rename_pkg::NCHECK; n++) begin
         mem[n] = rename_pkg::RESET_CHECKPOINT;
      end
   end

   // Single write port
   // The snapshot is taken on the accepting edge of the branch rename
   always_ff @(posedge clka) begin
      if (wr_en) begin
         mem[wr_ndx] <= wr_data;                  // Whole record, no partial writes
      end
   end

   // ============================
   // Read port
   // ============================

   // Zero latency so the restore lands at the very next edge
   // A write and a restore never meet in one cycle because a mispredict
   // holds rdy low, so no write-through path is kept here
   assign rd_data = mem[rd_ndx];

   // ============================
   // Checks
   // ============================

   // An unknown slot index would smear the write over several records
   // and corrupt snapshots that belong to older branches
   a_wr_ndx_known : assert property (
      @(posedge clka) wr_en |-> !$isunknown(wr_ndx)
   ) else $error("checkpoint_ram write index unknown while writing");

endmodule

//--- common/rename_pkg.sv
package rename_pkg;

   // ============================
   // Sizes
   // ============================
   localparam int AREGS  = 8;                     // Architectural registers seen by software
   localparam int PREGS  = 32;                    // Physical registers behind the map
   localparam int NCHECK = 4;                     // Branch checkpoints held at once

   // Widths that carry a meaning
   typedef logic [$clog2(AREGS)-1:0]  areg_t;          // Architectural register number
   typedef logic [$clog2(PREGS)-1:0]  preg_t;          // Physical register number
   typedef logic [$clog2(NCHECK)-1:0] checkpt_ndx_t;   // Checkpoint slot index
   typedef logic [PREGS-1:0]          avail_t;         // One bit per physical register, 1 is free
   typedef preg_t [AREGS-1:0]         rename_map_t;    // Entry i holds the mapping of areg i

   // A full snapshot of the rename state, taken at each branch
   typedef struct packed {
      rename_map_t map;
      avail_t      avail;
   } checkpoint_t;

   // ============================
   // Pipeline records
   // ============================
   typedef struct packed {
      logic  valid;                               // A request is present
      logic  is_branch;                           // Take a checkpoint with this rename
      logic  has_dst;                             // Allocate a new destination
      areg_t src1;
      areg_t src2;
      areg_t dst;
   } rename_req_t;

   typedef struct packed {
      preg_t        psrc1;
      preg_t        psrc2;
      preg_t        pdst;                         // Lowest free register at request time
      preg_t        old_pdst;                     // Previous mapping of dst, freed at commit
      checkpt_ndx_t ckpt;                         // Only meaningful for a branch
      logic         valid;                        // Request accepted this cycle
   } rename_rsp_t;

   typedef struct packed {
      logic  valid;
      preg_t free_preg;                           // Register handed back by retire
   } commit_t;

   typedef struct packed {
      logic         valid;
      logic         mispredict;                   // Roll back to the checkpoint
      checkpt_ndx_t ckpt;                         // Checkpoint of the resolving branch
   } resolve_t;

   // Identity map, each architectural register points at the same numbered preg
   function automatic rename_map_t reset_map();
      rename_map_t m;
      for (int i = 0; i < AREGS; i++) begin
         m[i] = preg_t'(i);
      end
      return m;
   endfunction

   // The first AREGS physical registers are in use out of reset
   localparam avail_t RESET_AVAIL = {{(PREGS-AREGS){1'b1}}, {AREGS{1'b0}}};

   localparam checkpoint_t RESET_CHECKPOINT = '{map: reset_map(), avail: RESET_AVAIL};

endpackage

//--- dv/rename_unit_tb.sv
module rename_unit_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int DRIVE_DELAY = 2;                // Inputs change this long after each edge
   localparam int SETTLE      = 20;               // Outputs are sampled this long after a drive
   localparam int WAIT_LIMIT  = 40;               // Cycles any single wait may take

   logic                    clka;
   logic                    rst_n;
   rename_pkg::rename_req_t req;
   rename_pkg::commit_t     commit;
   rename_pkg::resolve_t    resolve;
   logic                    rdy;
   rename_pkg::rename_rsp_t rsp;

   // ==============================
   // Reference model
   // ==============================
   rename_pkg::rename_map_t       m_map;                          // Expected map
   rename_pkg::avail_t            m_avail;                        // Expected free bitmap
   rename_pkg::rename_map_t       saved_map [rename_pkg::NCHECK]; // Copies taken at branches
   rename_pkg::avail_t            saved_avail [rename_pkg::NCHECK];
   logic [rename_pkg::NCHECK-1:0] m_inuse;                        // Outstanding checkpoints
   rename_pkg::checkpt_ndx_t      m_tail;                         // Index the next branch gets
   int                            errors;

   tb_clock_gen u_clk (
      .clka  (clka),
      .rst_n (rst_n)
   );

   rename_unit dut (
      .clka    (clka),
      .rst_n   (rst_n),
      .req     (req),
      .commit  (commit),
      .resolve (resolve),
      .rdy     (rdy),
      .rsp     (rsp)
   );

   // ==============================
   // Helpers
   // ==============================
   task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      errors++;
      $display("FAILED at %0t: %s expected %0d, got %0d", $time, sig, exp_val, act_val);
   endtask

   // Ends the run at once when the DUT stops answering
   task automatic abort_run(input string why);
      errors++;
      $display("%0t: %s", $time, why);
      $display("Checks done, %0d errors", errors);
      $display("Testbench failed");
      $finish;
   endtask

   // The free register with the smallest number
   function automatic rename_pkg::preg_t lowest_free(input rename_pkg::avail_t av);
      for (int i = 0; i < rename_pkg::PREGS; i++) begin
         if (av[i]) begin
            return rename_pkg::preg_t'(i);
         end
      end
      return '0;
   endfunction

   function automatic rename_pkg::areg_t rand_areg();
      return rename_pkg::areg_t'($urandom_range(rename_pkg::AREGS - 1, 0));
   endfunction

   // A register that is taken but no longer mapped, as retire would hand back
   function automatic int retired_preg();
      logic mapped;
      for (int p = 0; p < rename_pkg::PREGS; p++) begin
         mapped = 1'b0;
         for (int a = 0; a < rename_pkg::AREGS; a++) begin
            if (m_map[a] == p) begin
               mapped = 1'b1;
            end
         end
         if (!m_avail[p] && !mapped) begin
            return p;
         end
      end
      return -1;
   endfunction

   // Drive one request, wait for rdy, check rsp, then update the model at the accepting edge
   task automatic issue_rename(input logic br, input logic hd, input rename_pkg::areg_t s1,
                               input rename_pkg::areg_t s2, input rename_pkg::areg_t d);
      rename_pkg::preg_t exp_pdst;
      int                waited;
      req.valid     = 1'b1;
      req.is_branch = br;
      req.has_dst   = hd;
      req.src1      = s1;
      req.src2      = s2;
      req.dst       = d;
      waited        = 0;
      #(SETTLE);
      while (rdy !== 1'b1) begin
         if (waited >= WAIT_LIMIT) begin
            abort_run("Rename request was never accepted");
         end
         @(posedge clka);
         #(DRIVE_DELAY + SETTLE);
         waited++;
      end
      exp_pdst = lowest_free(m_avail);
      if (rsp.valid !== 1'b1) report_mismatch("rsp.valid", 1, rsp.valid);
      if (rsp.psrc1 !== m_map[s1]) report_mismatch("rsp.psrc1", m_map[s1], rsp.psrc1);
      if (rsp.psrc2 !== m_map[s2]) report_mismatch("rsp.psrc2", m_map[s2], rsp.psrc2);
      if (rsp.old_pdst !== m_map[d]) report_mismatch("rsp.old_pdst", m_map[d], rsp.old_pdst);
      if (hd && rsp.pdst !== exp_pdst) report_mismatch("rsp.pdst", exp_pdst, rsp.pdst);
      if (br && rsp.ckpt !== m_tail) report_mismatch("rsp.ckpt", m_tail, rsp.ckpt);
      if (br) begin                               // Snapshot is the state before this rename
         saved_map[m_tail]   = m_map;
         saved_avail[m_tail] = m_avail;
         m_inuse[m_tail]     = 1'b1;
         m_tail              = m_tail + 1'b1;
      end
      if (hd) begin
         m_map[d]          = exp_pdst;
         m_avail[exp_pdst] = 1'b0;
      end
      @(posedge clka);
      #(DRIVE_DELAY);
      req.valid = 1'b0;
   endtask

   // Look at rdy for a request shape without presenting it
   task automatic probe_rdy(input logic br, input logic hd, input logic exp_rdy);
      req.valid     = 1'b0;
      req.is_branch = br;
      req.has_dst   = hd;
      #(SETTLE);
      if (rdy !== exp_rdy) report_mismatch("rdy", exp_rdy, rdy);
      @(posedge clka);
      #(DRIVE_DELAY);
   endtask

   task automatic apply_commit(input int p);
      commit.valid     = 1'b1;
      commit.free_preg = rename_pkg::preg_t'(p);
      @(posedge clka);
      #(DRIVE_DELAY);
      commit.valid = 1'b0;
      m_avail[p]   = 1'b1;
   endtask

   // One resolve cycle during which any request in req stays held
   task automatic resolve_branch(input rename_pkg::checkpt_ndx_t k, input logic mis);
      rename_pkg::checkpt_ndx_t j;
      resolve.valid      = 1'b1;
      resolve.mispredict = mis;
      resolve.ckpt       = k;
      #(SETTLE);
      if (mis && rdy !== 1'b0) report_mismatch("rdy", 0, rdy);
      if (mis && rsp.valid !== 1'b0) report_mismatch("rsp.valid", 0, rsp.valid);
      @(posedge clka);
      #(DRIVE_DELAY);
      resolve.valid      = 1'b0;
      resolve.mispredict = 1'b0;
      if (mis) begin
         m_map   = saved_map[k];
         m_avail = saved_avail[k] | m_avail;      // Registers taken after the branch return
         j       = k;
         do begin                                 // Drop k and every younger checkpoint
            m_inuse[j] = 1'b0;
            j          = j + 1'b1;
         end while (j != m_tail);
         m_tail = k;
      end else begin
         m_inuse[k] = 1'b0;
      end
   endtask

   // ==============================
   // Tests
   // ==============================
   task automatic test_reset_state();
      issue_rename(1'b0, 1'b0, 3'd1, 3'd6, 3'd0);  // Identity map seen through the sources
      for (int i = 0; i < 4; i++) begin
         issue_rename(1'b0, 1'b1, rename_pkg::areg_t'(i + 4), rename_pkg::areg_t'(i + 5),
                      rename_pkg::areg_t'(i));
      end
   endtask

   task automatic test_dependency_chains();
      for (int i = 0; i < 12; i++) begin
         issue_rename(1'b0, $urandom_range(3, 0) != 0, rand_areg(), rand_areg(), rand_areg());
      end
   endtask

   task automatic test_free_list_backpressure();
      int                p;
      rename_pkg::areg_t s1;
      rename_pkg::areg_t s2;
      rename_pkg::areg_t d;
      while (m_avail != '0) begin                 // Use up the rest of the 24 free registers
         issue_rename(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg());
      end
      probe_rdy(1'b0, 1'b1, 1'b0);
      probe_rdy(1'b0, 1'b0, 1'b1);
      p  = retired_preg();
      s1 = rand_areg();
      s2 = rand_areg();
      d  = rand_areg();
      req.valid        = 1'b1;                    // Held request stalls in the commit cycle
      req.is_branch    = 1'b0;
      req.has_dst      = 1'b1;
      req.src1         = s1;
      req.src2         = s2;
      req.dst          = d;
      commit.valid     = 1'b1;
      commit.free_preg = rename_pkg::preg_t'(p);
      #(SETTLE);
      if (rdy !== 1'b0) report_mismatch("rdy", 0, rdy);
      @(posedge clka);
      #(DRIVE_DELAY);
      commit.valid = 1'b0;
      m_avail[p]   = 1'b1;
      #(SETTLE);
      if (rdy !== 1'b1) report_mismatch("rdy", 1, rdy);
      if (rsp.pdst !== p) report_mismatch("rsp.pdst", p, rsp.pdst);
      issue_rename(1'b0, 1'b1, s1, s2, d);
      for (int n = 0; n < 10; n++) begin          // Room for the branch tests
         p = retired_preg();
         if (p >= 0) begin
            apply_commit(p);
         end
      end
   endtask

   task automatic test_mispredict_restore();
      rename_pkg::checkpt_ndx_t k;
      k = m_tail;
      issue_rename(1'b1, 1'b1, rand_areg(), rand_areg(), rand_areg());
      for (int i = 0; i < 3; i++) begin
         issue_rename(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg());
      end
      req.valid     = 1'b1;
      req.is_branch = 1'b0;
      req.has_dst   = 1'b0;
      req.src1      = 3'd2;
      req.src2      = 3'd5;
      resolve_branch(k, 1'b1);
      issue_rename(1'b0, 1'b0, 3'd2, 3'd5, 3'd0);  // Same request seen through the restored map
      for (int i = 0; i < 4; i++) begin
         issue_rename(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg());
      end
   endtask

   task automatic test_checkpoint_exhaustion();
      rename_pkg::checkpt_ndx_t k;
      for (int i = 0; i < rename_pkg::NCHECK; i++) begin
         issue_rename(1'b1, 1'b0, rand_areg(), rand_areg(), 3'd0);
      end
      k             = m_tail;                     // Ring is full so the tail is the oldest
      req.valid     = 1'b1;
      req.is_branch = 1'b1;
      req.has_dst   = 1'b0;
      req.src1      = 3'd3;
      req.src2      = 3'd4;
      req.dst       = 3'd0;
      #(SETTLE);
      if (rdy !== 1'b0) report_mismatch("rdy", 0, rdy);
      if (rsp.valid !== 1'b0) report_mismatch("rsp.valid", 0, rsp.valid);
      @(posedge clka);
      #(DRIVE_DELAY);
      resolve_branch(k, 1'b0);
      issue_rename(1'b1, 1'b0, 3'd3, 3'd4, 3'd0);
      for (int i = 0; i < rename_pkg::NCHECK; i++) begin
         if (m_inuse[i]) begin
            resolve_branch(rename_pkg::checkpt_ndx_t'(i), 1'b0);
         end
      end
   endtask

   task automatic test_nested_mispredict();
      rename_pkg::checkpt_ndx_t k;
      k = m_tail;
      issue_rename(1'b1, 1'b1, rand_areg(), rand_areg(), rand_areg());
      issue_rename(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg());
      issue_rename(1'b1, 1'b1, rand_areg(), rand_areg(), rand_areg());
      issue_rename(1'b0, 1'b1, rand_areg(), rand_areg(), rand_areg());
      issue_rename(1'b1, 1'b0, rand_areg(), rand_areg(), 3'd0);
      req.valid     = 1'b1;
      req.is_branch = 1'b0;
      req.has_dst   = 1'b0;
      req.src1      = 3'd0;
      req.src2      = 3'd1;
      resolve_branch(k, 1'b1);
      for (int a = 0; a < rename_pkg::AREGS; a += 2) begin  // Read back the whole map
         issue_rename(1'b0, 1'b0, rename_pkg::areg_t'(a), rename_pkg::areg_t'(a + 1), 3'd0);
      end
      // All three squashed slots are handed out again, starting at the oldest index
      for (int i = 0; i < 3; i++) begin
         issue_rename(1'b1, 1'b0, rand_areg(), rand_areg(), 3'd0);
      end
      for (int i = 0; i < rename_pkg::NCHECK; i++) begin
         if (m_inuse[i]) begin
            resolve_branch(rename_pkg::checkpt_ndx_t'(i), 1'b0);
         end
      end
   endtask

   // ==============================
   // Main sequence
   // ==============================
   initial begin
      int waited;
      errors  = 0;
      req     = '0;
      commit  = '0;
      resolve = '0;
      for (int i = 0; i < rename_pkg::AREGS; i++) begin
         m_map[i] = rename_pkg::preg_t'(i);       // Reset map is the identity
      end
      m_avail = '1;
      for (int i = 0; i < rename_pkg::AREGS; i++) begin
         m_avail[i] = 1'b0;
      end
      m_inuse = '0;
      m_tail  = '0;
      void'($urandom(32'hd3e1_e5d1));
      waited = 0;
      while (rst_n !== 1'b1) begin
         if (waited >= WAIT_LIMIT) begin
            abort_run("Reset was never released");
         end
         @(posedge clka);
         #(DRIVE_DELAY);
         waited++;
      end
      test_reset_state();
      test_dependency_chains();
      test_free_list_backpressure();
      test_mispredict_restore();
      test_checkpoint_exhaustion();
      test_nested_mispredict();
      $display("Checks done, %0d errors", errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- dv/tb_clock_gen.sv
module tb_clock_gen (
   output logic clka,                             // Free running 100 ns clock
   output logic rst_n                             // Active low reset for the DUT
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int HALF_PERIOD  = 50;
   localparam int RESET_CYCLES = 16;

   initial begin
      clka = 1'b0;
      forever #(HALF_PERIOD) clka = ~clka;
   end

   // Release just after a rising edge so no flop sees it change at the edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clka);
      #1 rst_n = 1'b1;
   end

endmodule

//--- hdl/rename_unit.sv
module rename_unit (
   input  logic                       clka,
   input  logic                       rst_n,
   input  rename_pkg::rename_req_t    req,        // From the rename stage, held while rdy is low
   input  rename_pkg::commit_t        commit,     // From retire
   input  rename_pkg::resolve_t       resolve,    // From the branch unit
   output logic                       rdy,        // Request can be taken at this edge
   output rename_pkg::rename_rsp_t    rsp         // Combinational result for the request
);

   // ============================
   // Internal nets
   // ============================

   logic                       accept;            // Handshake completes at this edge
   logic                       alloc;             // Accepted branch takes a checkpoint
   logic                       mispredict;        // Rollback requested this cycle
   logic                       free_any;
   logic                       can_alloc;
   rename_pkg::checkpt_ndx_t   free_ndx;
   rename_pkg::checkpoint_t    cur_state;         // Live map and avail
   rename_pkg::checkpoint_t    saved_state;       // Snapshot read for the restore
   rename_pkg::rename_rsp_t    map_rsp;

   assign mispredict = resolve.valid & resolve.mispredict;

   // Stall on a rollback, on an empty free list for a destination,
   // or on a full checkpoint ring for a branch
   assign rdy = ~(mispredict
                | (req.has_dst & ~free_any)
                | (req.is_branch & ~can_alloc));

   assign accept = req.valid & rdy;
   assign alloc  = accept & req.is_branch;

   // The branch learns which slot holds its snapshot
   always_comb begin
      rsp      = map_rsp;
      rsp.ckpt = free_ndx;
   end

   // ============================
   // Blocks
   // ============================

   rename_map u_map (
      .clka       (clka),
      .rst_n      (rst_n),
      .req        (req),
      .accept     (accept),
      .commit     (commit),
      .restore_en (mispredict),
      .restore    (saved_state),
      .rsp        (map_rsp),
      .state      (cur_state),
      .free_any   (free_any)
   );

   checkpoint_alloc u_alloc (
      .clka       (clka),
      .rst_n      (rst_n),
      .alloc      (alloc),
      .resolve    (resolve),
      .free_ndx   (free_ndx),
      .can_alloc  (can_alloc)
   );

   checkpoint_ram u_ckpt_ram (
      .clka       (clka),
      .wr_en      (alloc),
      .wr_ndx     (free_ndx),                     // Tail slot of the ring
      .wr_data    (cur_state),
      .rd_ndx     (resolve.ckpt),
      .rd_data    (saved_state)
   );

endmodule

//--- rename/rename_map.sv
module rename_map (
   input  logic                       clka,
   input  logic                       rst_n,
   input  rename_pkg::rename_req_t    req,        // Instruction being renamed
   input  logic                       accept,     // req.valid and rdy at this edge
   input  rename_pkg::commit_t        commit,     // Register released by retire
   input  logic                       restore_en, // Mispredict in this cycle
   input  rename_pkg::checkpoint_t    restore,    // Snapshot of the mispredicted branch
   output rename_pkg::rename_rsp_t    rsp,        // Everything but the checkpoint index
   output rename_pkg::checkpoint_t    state,      // Current map and avail for a snapshot
   output logic                       free_any    // At least one register can be taken
);

   // ============================
   // State
   // ============================

   rename_pkg::rename_map_t map_q;                // Speculative arch to phys map
   rename_pkg::avail_t      avail_q;              // 1 means the register is free
   rename_pkg::rename_map_t map_d;
   rename_pkg::avail_t      avail_d;
   rename_pkg::preg_t       pdst_sel;             // Lowest free register

   // ============================
   // Free register pick
   // ============================

   // Walk from the top down so the last hit is the lowest set bit
   // When avail is empty the pick is 0, and rdy already blocks the request
   always_comb begin
      pdst_sel = '0;
      for (int i = rename_pkg::PREGS - 1; i >= 0; i--) begin
         if (avail_q[i]) begin
            pdst_sel = rename_pkg::preg_t'(i);
         end
      end
   end

   assign free_any = |avail_q;

   // ============================
   // Lookup
   // ============================

   // All lookups see the state before this cycle's edge
   // A source equal to dst in the same instruction therefore reads the old mapping
   always_comb begin
      rsp          = '0;
      rsp.psrc1    = map_q[req.src1];
      rsp.psrc2    = map_q[req.src2];
      rsp.pdst     = pdst_sel;
      rsp.old_pdst = map_q[req.dst];              // Goes down the pipe to be freed at commit
      rsp.valid    = accept;
   end

   // The snapshot a branch saves is the state it sees, before its own rename
   assign state.map   = map_q;
   assign state.avail = avail_q;

   // ============================
   // Next state
   // ============================

   always_comb begin
      map_d   = map_q;
      avail_d = avail_q;
      // Restore first so a commit in the same cycle still lands
      if (restore_en) begin
         map_d   = restore.map;
         // Keep everything freed since the branch and hand back everything taken after it
         avail_d = restore.avail | avail_q;
      end
      if (commit.valid) begin
         avail_d[commit.free_preg] = 1'b1;        // Usable from the next cycle only
      end
      // No accept can happen together with a restore
      if (accept && req.has_dst) begin
         map_d[req.dst]    = pdst_sel;
         avail_d[pdst_sel] = 1'b0;
      end
   end

   always_ff @(posedge clka or negedge rst_n) begin
      if (!rst_n) begin
         map_q   <= rename_pkg::RESET_CHECKPOINT.map;    // Identity map
         avail_q <= rename_pkg::RESET_CHECKPOINT.avail;  // Low AREGS registers taken
      end else begin
         map_q   <= map_d;
         avail_q <= avail_d;
      end
   end

   // ============================
   // Checks
   // ============================

   // A double free would let two architectural registers share one preg
   // once both get reallocated
   a_commit_not_free : assert property (
      @(posedge clka) disable iff (!rst_n)
      commit.valid |-> !avail_q[commit.free_preg]
   ) else $error("commit frees preg %0d which is already free", commit.free_preg);

endmodule

//--- verilog.f
common/rename_pkg.sv
checkpoint/checkpoint_ram.sv
checkpoint/checkpoint_alloc.sv
rename/rename_map.sv
hdl/rename_unit.sv
dv/tb_clock_gen.sv
dv/rename_unit_tb.sv
